// ==== logic/agen_pkg.sv ====
package agen_pkg;

   // Datapath widths
   localparam int addr_w   = 32;
   localparam int seg_w    = 16;
   localparam int rid_w    = 3;
   localparam int aluk_w   = 3;
   localparam int gpr_sb_w = 24;
   localparam int seg_sb_w = 8;
   localparam int mm_sb_w  = 8;

   // Operand size codes
   localparam logic [1:0] size_8  = 2'd0;
   localparam logic [1:0] size_16 = 2'd1;
   localparam logic [1:0] size_32 = 2'd2;
   localparam logic [1:0] size_64 = 2'd3;

   // IDT entry addresses for the supported faults
   localparam logic [addr_w-1:0] idt_nmi_addr = 32'h0000_0010;
   localparam logic [addr_w-1:0] idt_pf_addr  = 32'h0000_0070;
   localparam logic [addr_w-1:0] idt_gp_addr  = 32'h0000_0068;

   typedef struct packed {
      logic [addr_w-1:0] eip;
      logic [addr_w-1:0] neip;
      logic [seg_w-1:0]  ncs;
      logic [addr_w-1:0] a;
      logic [addr_w-1:0] b;
      logic [addr_w-1:0] add_base_disp;
      logic [addr_w-1:0] add_sib_seg1;
      logic [addr_w-1:0] sib_si_data;
      logic [addr_w-1:0] sp_addr;
      logic [addr_w-1:0] interrupt_addr;
      logic              exc_en_v;
      logic              mem_rd;
      logic              mem_wr;
      logic [aluk_w-1:0] aluk;
   } agen_data_t;

   typedef struct packed {
      logic [gpr_sb_w-1:0] gpr_sb;
      logic [seg_sb_w-1:0] seg_sb;
      logic [mm_sb_w-1:0]  mm_sb;
      logic [rid_w-1:0]    drid1;
      logic [rid_w-1:0]    drid2;
   } agen_sb_t;

   // Lanes of one GPR touched by an access of the given size
   // Register r, lane k lives at bit 3r+k
   function automatic logic [gpr_sb_w-1:0] gpr_lane_mask(input logic [rid_w-1:0] id,
                                                         input logic [1:0] size);
      logic [gpr_sb_w-1:0] lanes;
      case (size)
         size_8:  lanes = gpr_sb_w'(3'b001);
         size_16: lanes = gpr_sb_w'(3'b011);
         default: lanes = gpr_sb_w'(3'b111);
      endcase
      return lanes << (3 * id);
   endfunction

endpackage

// ==== logic/pipe_latch.sv ====
module pipe_latch #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     load,
   input  logic     in_v,
   input  payload_t d,
   output logic     out_v,
   output payload_t q
);

   // A stalled or empty slot becomes a bubble
   always_ff @(posedge clk) begin
      if (reset) begin
         out_v <= 1'b0;
      end else begin
         out_v <= in_v & load;
      end
   end

   // Payload only moves with a real instruction, otherwise it holds
   always_ff @(posedge clk) begin
      if (in_v && load) begin
         q <= d;
      end
   end

   no_valid_after_reset: assert property (@(posedge clk) reset |=> !out_v)
      else $error("pipe_latch valid set right after reset");

endmodule

// ==== logic/stack_pointer_unit.sv ====
module stack_pointer_unit import agen_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   input  logic              advance,
   input  logic [addr_w-1:0] sr2_data,
   input  logic [1:0]        mem_size,
   input  logic              sp_push,
   input  logic              sp_add_size,
   input  logic              temp_sp,
   output logic [addr_w-1:0] sp_addr
);

   logic [addr_w-1:0] push_off;
   logic [3:0]        pop_size;
   logic [3:0]        prev_pop_size;
   logic [addr_w-1:0] temp_sp_q;
   logic [addr_w-1:0] add_amt;
   logic [addr_w-1:0] sp_base;

   // Push decrements by the operand size, byte pushes count as words
   always_comb begin
      case (mem_size)
         size_32: push_off = addr_w'(-4);
         size_64: push_off = addr_w'(-8);
         default: push_off = addr_w'(-2);
      endcase
   end

   always_comb begin
      case (mem_size)
         size_32: pop_size = 4'd4;
         size_64: pop_size = 4'd8;
         default: pop_size = 4'd2;
      endcase
   end

   // Multi-pop steps by the size popped on the previous access
   assign add_amt = sp_add_size ? addr_w'(prev_pop_size) : push_off;
   assign sp_base = temp_sp ? temp_sp_q : sr2_data;
   assign sp_addr = sp_base + (sp_push ? add_amt : '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         temp_sp_q     <= '0;
         prev_pop_size <= '0;
      end else if (advance) begin
         temp_sp_q     <= sp_addr;
         prev_pop_size <= pop_size;
      end
   end

   no_byte_push: assert property (@(posedge clk) disable iff (reset)
      advance && sp_push |-> mem_size != size_8)
      else $error("stack access with byte size");

endmodule

// ==== logic/reg_dependency_check.sv ====
module reg_dependency_check import agen_pkg::*; (
   input  logic                v,
   input  logic [rid_w-1:0]    sr1, sr2, sib_i, seg1, seg2,
   input  logic [1:0]          sr1_size, sr2_size,
   input  logic                sr1_needed, sr2_needed,
   input  logic                seg1_needed, seg2_needed,
   input  logic                mm1_needed, mm2_needed,
   input  logic                sib_en,
   input  logic                ag2_v,
   input  logic [gpr_sb_w-1:0] ag2_gpr_sb,
   input  logic [seg_sb_w-1:0] ag2_seg_sb,
   input  logic [mm_sb_w-1:0]  ag2_mm_sb,
   input  logic                me_v,
   input  logic [gpr_sb_w-1:0] me_gpr_sb,
   input  logic [seg_sb_w-1:0] me_seg_sb,
   input  logic [mm_sb_w-1:0]  me_mm_sb,
   input  logic                me2_v,
   input  logic [gpr_sb_w-1:0] me2_gpr_sb,
   input  logic [seg_sb_w-1:0] me2_seg_sb,
   input  logic [mm_sb_w-1:0]  me2_mm_sb,
   input  logic                ex_v,
   input  logic [gpr_sb_w-1:0] ex_gpr_sb,
   input  logic [seg_sb_w-1:0] ex_seg_sb,
   input  logic [mm_sb_w-1:0]  ex_mm_sb,
   output logic                dep_stall
);

   logic [gpr_sb_w-1:0] gpr_need, gpr_busy;
   logic [seg_sb_w-1:0] seg_need, seg_busy;
   logic [mm_sb_w-1:0]  mm_need, mm_busy;

   // Lanes and registers read by this instruction
   always_comb begin
      gpr_need = '0;
      seg_need = '0;
      mm_need  = '0;
      if (sr1_needed)
         gpr_need = gpr_need | gpr_lane_mask(sr1, sr1_size);
      if (sr2_needed)
         gpr_need = gpr_need | gpr_lane_mask(sr2, sr2_size);
      // SIB index is always a full 32-bit read
      if (sib_en)
         gpr_need = gpr_need | gpr_lane_mask(sib_i, size_32);
      if (seg1_needed)
         seg_need[seg1] = 1'b1;
      if (seg2_needed)
         seg_need[seg2] = 1'b1;
      if (mm1_needed)
         mm_need[sr1] = 1'b1;
      if (mm2_needed)
         mm_need[sr2] = 1'b1;
   end

   // Pending writes from every valid later stage
   assign gpr_busy = ({gpr_sb_w{ag2_v}} & ag2_gpr_sb) | ({gpr_sb_w{me_v}} & me_gpr_sb)
                   | ({gpr_sb_w{me2_v}} & me2_gpr_sb) | ({gpr_sb_w{ex_v}} & ex_gpr_sb);
   assign seg_busy = ({seg_sb_w{ag2_v}} & ag2_seg_sb) | ({seg_sb_w{me_v}} & me_seg_sb)
                   | ({seg_sb_w{me2_v}} & me2_seg_sb) | ({seg_sb_w{ex_v}} & ex_seg_sb);
   assign mm_busy  = ({mm_sb_w{ag2_v}} & ag2_mm_sb) | ({mm_sb_w{me_v}} & me_mm_sb)
                   | ({mm_sb_w{me2_v}} & me2_mm_sb) | ({mm_sb_w{ex_v}} & ex_mm_sb);

   assign dep_stall = v & ((|(gpr_need & gpr_busy)) | (|(seg_need & seg_busy))
                        | (|(mm_need & mm_busy)));

endmodule

// ==== logic/all_scoreboard_generator.sv ====
module all_scoreboard_generator import agen_pkg::*; (
   input  logic                v,
   input  logic [rid_w-1:0]    drid1, drid2,
   input  logic [1:0]          dr1_size, dr2_size,
   input  logic                ld_gpr1, ld_gpr2,
   input  logic                ld_seg, ld_mm,
   output logic [gpr_sb_w-1:0] gpr_sb,
   output logic [seg_sb_w-1:0] seg_sb,
   output logic [mm_sb_w-1:0]  mm_sb
);

   always_comb begin
      gpr_sb = '0;
      seg_sb = '0;
      mm_sb  = '0;
      if (v) begin
         if (ld_gpr1)
            gpr_sb = gpr_sb | gpr_lane_mask(drid1, dr1_size);
         if (ld_gpr2)
            gpr_sb = gpr_sb | gpr_lane_mask(drid2, dr2_size);
         // Segment and MM writes always target the first destination
         if (ld_seg)
            seg_sb[drid1] = 1'b1;
         if (ld_mm)
            mm_sb[drid1] = 1'b1;
      end
   end

   // No clock here, so checked as the outputs settle
   always_comb begin
      if (!v) begin
         sb_clear_without_v: assert (gpr_sb == '0 && seg_sb == '0 && mm_sb == '0)
            else $error("scoreboard bit set without valid");
      end
   end

endmodule

// ==== logic/agen_stage1.sv ====
module agen_stage1 import agen_pkg::*; (
   input  logic                clk,
   input  logic                reset,
   input  logic                v,
   input  logic [addr_w-1:0]   eip,
   input  logic [seg_w-1:0]    cs,
   input  logic [47:0]         offset,
   input  logic                jmp_rel, mux_next_eip, mux_next_cs,
   input  logic [1:0]          mux_a,
   input  logic                mux_b, mux_drid1,
   input  logic                sp_push, sp_add_size, temp_sp,
   input  logic                sr1_needed, sr2_needed, seg1_needed, seg2_needed,
   input  logic                mm1_needed, mm2_needed,
   input  logic                ld_gpr1, ld_gpr2, ld_seg, ld_mm,
   input  logic [rid_w-1:0]    sr1, sr2, sib_i, seg1, seg2,
   input  logic [1:0]          sr1_size, sr2_size, dr1_size, dr2_size, mem_size,
   input  logic [addr_w-1:0]   imm32, disp32,
   input  logic                sib_en, disp_en, base_reg_en, mux_seg,
   input  logic [1:0]          sib_s,
   input  logic [addr_w-1:0]   sr1_data, sr2_data, sib_i_data,
   input  logic [seg_w-1:0]    seg1_data, seg2_data,
   input  logic                nmi_int_en, gen_prot_exc_en, page_fault_exc_en,
   input  logic                mem_rd, mem_wr,
   input  logic [aluk_w-1:0]   aluk,
   input  logic                ag2_v, me_v, me2_v, ex_v,
   input  logic [gpr_sb_w-1:0] ag2_gpr_sb, me_gpr_sb, me2_gpr_sb, ex_gpr_sb,
   input  logic [seg_sb_w-1:0] ag2_seg_sb, me_seg_sb, me2_seg_sb, ex_seg_sb,
   input  logic [mm_sb_w-1:0]  ag2_mm_sb, me_mm_sb, me2_mm_sb, ex_mm_sb,
   output logic                dep_stall,
   output logic [rid_w-1:0]    sr1_out, sr2_out, sib_i_out, seg1_out, seg2_out,
   output agen_data_t          data,
   output agen_sb_t            sb
);

   logic [addr_w-1:0]   rel_add;
   logic [seg_w-1:0]    seg_sel;
   logic [addr_w-1:0]   sib_si;
   logic [addr_w-1:0]   sp_addr;
   logic [rid_w-1:0]    drid1;
   logic [gpr_sb_w-1:0] gpr_sb;
   logic [seg_sb_w-1:0] seg_sb;
   logic [mm_sb_w-1:0]  mm_sb;
   logic                advance;

   // Register file read ids go straight out
   assign sr1_out   = sr1;
   assign sr2_out   = sr2;
   assign sib_i_out = sib_i;
   assign seg1_out  = seg1;
   assign seg2_out  = seg2;

   assign advance = v & ~dep_stall;
   assign rel_add = jmp_rel ? offset[addr_w-1:0] : '0;
   assign seg_sel = mux_seg ? cs : seg1_data;
   assign sib_si  = sib_en ? (sib_i_data << sib_s) : '0;
   assign drid1   = mux_drid1 ? sr2 : sr1;

   always_comb begin
      data.eip  = eip;
      data.neip = mux_next_eip ? offset[addr_w-1:0] : eip + rel_add;
      // Far transfers take the selector from the top of the offset
      data.ncs  = mux_next_cs ? offset[47:32] : cs;
      case (mux_a)
         2'd0:    data.a = sr1_data;
         2'd1:    data.a = addr_w'(seg1_data);
         2'd2:    data.a = addr_w'(seg2_data);
         default: data.a = addr_w'(cs);
      endcase
      data.b             = mux_b ? imm32 : sr2_data;
      data.add_base_disp = (base_reg_en ? sr1_data : '0) + (disp_en ? disp32 : '0);
      data.add_sib_seg1  = {seg_sel, 16'b0} + sib_si;
      data.sib_si_data   = sib_si;
      data.sp_addr       = sp_addr;
      // GP beats PF beats NMI, and NMI is the idle vector
      if (gen_prot_exc_en)
         data.interrupt_addr = idt_gp_addr;
      else if (page_fault_exc_en)
         data.interrupt_addr = idt_pf_addr;
      else
         data.interrupt_addr = idt_nmi_addr;
      data.exc_en_v = v & (nmi_int_en | gen_prot_exc_en | page_fault_exc_en);
      data.mem_rd   = mem_rd;
      data.mem_wr   = mem_wr;
      data.aluk     = aluk;
   end

   always_comb begin
      sb.gpr_sb = gpr_sb;
      sb.seg_sb = seg_sb;
      sb.mm_sb  = mm_sb;
      sb.drid1  = drid1;
      sb.drid2  = sr2;
   end

   stack_pointer_unit i_stack (
      .clk, .reset, .advance, .sr2_data, .mem_size,
      .sp_push, .sp_add_size, .temp_sp, .sp_addr
   );

   reg_dependency_check i_dep_check (
      .v, .sr1, .sr2, .sib_i, .seg1, .seg2, .sr1_size, .sr2_size,
      .sr1_needed, .sr2_needed, .seg1_needed, .seg2_needed,
      .mm1_needed, .mm2_needed, .sib_en,
      .ag2_v, .ag2_gpr_sb, .ag2_seg_sb, .ag2_mm_sb,
      .me_v, .me_gpr_sb, .me_seg_sb, .me_mm_sb,
      .me2_v, .me2_gpr_sb, .me2_seg_sb, .me2_mm_sb,
      .ex_v, .ex_gpr_sb, .ex_seg_sb, .ex_mm_sb,
      .dep_stall
   );

   all_scoreboard_generator i_sb_gen (
      .v, .drid1, .drid2(sr2), .dr1_size, .dr2_size,
      .ld_gpr1, .ld_gpr2, .ld_seg, .ld_mm,
      .gpr_sb, .seg_sb, .mm_sb
   );

   // Stall feedback from the dependency check must settle before every edge
   latch_valid_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(advance))
      else $error("stage latch valid is unknown");

endmodule

// ==== logic/agen_top.sv ====
module agen_top import agen_pkg::*; (
   input  logic                clk,
   input  logic                reset,
   input  logic                v,
   input  logic [addr_w-1:0]   eip,
   input  logic [seg_w-1:0]    cs,
   input  logic [47:0]         offset,
   input  logic                jmp_rel, mux_next_eip, mux_next_cs,
   input  logic [1:0]          mux_a,
   input  logic                mux_b, mux_drid1,
   input  logic                sp_push, sp_add_size, temp_sp,
   input  logic                sr1_needed, sr2_needed, seg1_needed, seg2_needed,
   input  logic                mm1_needed, mm2_needed,
   input  logic                ld_gpr1, ld_gpr2, ld_seg, ld_mm,
   input  logic [rid_w-1:0]    sr1, sr2, sib_i, seg1, seg2,
   input  logic [1:0]          sr1_size, sr2_size, dr1_size, dr2_size, mem_size,
   input  logic [addr_w-1:0]   imm32, disp32,
   input  logic                sib_en, disp_en, base_reg_en, mux_seg,
   input  logic [1:0]          sib_s,
   input  logic [addr_w-1:0]   sr1_data, sr2_data, sib_i_data,
   input  logic [seg_w-1:0]    seg1_data, seg2_data,
   input  logic                nmi_int_en, gen_prot_exc_en, page_fault_exc_en,
   input  logic                mem_rd, mem_wr,
   input  logic [aluk_w-1:0]   aluk,
   input  logic                ag2_v, me_v, me2_v, ex_v,
   input  logic [gpr_sb_w-1:0] ag2_gpr_sb, me_gpr_sb, me2_gpr_sb, ex_gpr_sb,
   input  logic [seg_sb_w-1:0] ag2_seg_sb, me_seg_sb, me2_seg_sb, ex_seg_sb,
   input  logic [mm_sb_w-1:0]  ag2_mm_sb, me_mm_sb, me2_mm_sb, ex_mm_sb,
   output logic                dep_stall,
   output logic [rid_w-1:0]    sr1_out, sr2_out, sib_i_out, seg1_out, seg2_out,
   output logic                ag_v,
   output logic [addr_w-1:0]   ag_neip,
   output logic [seg_w-1:0]    ag_ncs,
   output logic [addr_w-1:0]   ag_a, ag_b,
   output logic [addr_w-1:0]   ag_add_base_disp, ag_add_sib_seg1,
   output logic [addr_w-1:0]   ag_sp_addr, ag_interrupt_addr,
   output logic                ag_exc_en_v,
   output logic [gpr_sb_w-1:0] ag_gpr_sb,
   output logic [seg_sb_w-1:0] ag_seg_sb,
   output logic [mm_sb_w-1:0]  ag_mm_sb,
   output logic [rid_w-1:0]    ag_drid1
);

   agen_data_t stage_data, data_q;
   agen_sb_t   stage_sb, sb_q;
   logic       data_v, sb_v;
   logic       no_stall;

   assign no_stall = ~dep_stall;

   agen_stage1 i_stage1 (
      .data(stage_data),
      .sb(stage_sb),
      .*
   );

   pipe_latch #(.payload_t(agen_data_t)) i_data_latch (
      .clk, .reset, .load(no_stall), .in_v(v),
      .d(stage_data), .out_v(data_v), .q(data_q)
   );

   pipe_latch #(.payload_t(agen_sb_t)) i_sb_latch (
      .clk, .reset, .load(no_stall), .in_v(v),
      .d(stage_sb), .out_v(sb_v), .q(sb_q)
   );

   // Both halves of the stage register carry the same instruction
   assign ag_v              = data_v & sb_v;
   assign ag_neip           = data_q.neip;
   assign ag_ncs            = data_q.ncs;
   assign ag_a              = data_q.a;
   assign ag_b              = data_q.b;
   assign ag_add_base_disp  = data_q.add_base_disp;
   assign ag_add_sib_seg1   = data_q.add_sib_seg1;
   assign ag_sp_addr        = data_q.sp_addr;
   assign ag_interrupt_addr = data_q.interrupt_addr;
   assign ag_exc_en_v       = data_q.exc_en_v;
   assign ag_gpr_sb         = sb_q.gpr_sb;
   assign ag_seg_sb         = sb_q.seg_sb;
   assign ag_mm_sb          = sb_q.mm_sb;
   assign ag_drid1          = sb_q.drid1;

endmodule

// ==== dv/agen_tb.sv ====
module agen_tb import agen_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   logic                clk, reset, v;
   logic [addr_w-1:0]   eip;
   logic [seg_w-1:0]    cs;
   logic [47:0]         offset;
   logic                jmp_rel, mux_next_eip, mux_next_cs;
   logic [1:0]          mux_a;
   logic                mux_b, mux_drid1;
   logic                sp_push, sp_add_size, temp_sp;
   logic                sr1_needed, sr2_needed, seg1_needed, seg2_needed;
   logic                mm1_needed, mm2_needed;
   logic                ld_gpr1, ld_gpr2, ld_seg, ld_mm;
   logic [rid_w-1:0]    sr1, sr2, sib_i, seg1, seg2;
   logic [1:0]          sr1_size, sr2_size, dr1_size, dr2_size, mem_size;
   logic [addr_w-1:0]   imm32, disp32;
   logic                sib_en, disp_en, base_reg_en, mux_seg;
   logic [1:0]          sib_s;
   logic [addr_w-1:0]   sr1_data, sr2_data, sib_i_data;
   logic [seg_w-1:0]    seg1_data, seg2_data;
   logic                nmi_int_en, gen_prot_exc_en, page_fault_exc_en;
   logic                mem_rd, mem_wr;
   logic [aluk_w-1:0]   aluk;
   logic                ag2_v, me_v, me2_v, ex_v;
   logic [gpr_sb_w-1:0] ag2_gpr_sb, me_gpr_sb, me2_gpr_sb, ex_gpr_sb;
   logic [seg_sb_w-1:0] ag2_seg_sb, me_seg_sb, me2_seg_sb, ex_seg_sb;
   logic [mm_sb_w-1:0]  ag2_mm_sb, me_mm_sb, me2_mm_sb, ex_mm_sb;
   logic                dep_stall;
   logic [rid_w-1:0]    sr1_out, sr2_out, sib_i_out, seg1_out, seg2_out;
   logic                ag_v;
   logic [addr_w-1:0]   ag_neip;
   logic [seg_w-1:0]    ag_ncs;
   logic [addr_w-1:0]   ag_a, ag_b;
   logic [addr_w-1:0]   ag_add_base_disp, ag_add_sib_seg1;
   logic [addr_w-1:0]   ag_sp_addr, ag_interrupt_addr;
   logic                ag_exc_en_v;
   logic [gpr_sb_w-1:0] ag_gpr_sb;
   logic [seg_sb_w-1:0] ag_seg_sb;
   logic [mm_sb_w-1:0]  ag_mm_sb;
   logic [rid_w-1:0]    ag_drid1;

   // One parsed line of the cases file
   logic [8*20-1:0]     name;
   logic [8*3-1:0]      kind;
   logic [63:0]         ctl, d0, d1, d2, d3, e0, e1;
   logic [8*200-1:0]    line;
   int                  fd, n_fields, n_tests, n_fail, errs;

   agen_top i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Controls off, data inputs and idle scoreboards random
   task automatic drive_idle();
      v = 1'b0;
      eip = $urandom;
      cs = 16'($urandom);
      offset = {16'($urandom), $urandom};
      {jmp_rel, mux_next_eip, mux_next_cs} = '0;
      mux_a = 2'($urandom);
      mux_b = 1'($urandom);
      mux_drid1 = 1'b0;
      {sp_push, sp_add_size, temp_sp} = '0;
      {sr1_needed, sr2_needed, seg1_needed, seg2_needed, mm1_needed, mm2_needed} = '0;
      {ld_gpr1, ld_gpr2, ld_seg, ld_mm} = '0;
      sr1 = 3'($urandom);
      sr2 = 3'($urandom);
      sib_i = 3'($urandom);
      seg1 = 3'($urandom);
      seg2 = 3'($urandom);
      {sr1_size, sr2_size, dr1_size, dr2_size, mem_size} = {5{size_32}};
      imm32 = $urandom;
      disp32 = $urandom;
      {sib_en, disp_en, base_reg_en, mux_seg} = '0;
      sib_s = 2'($urandom);
      sr1_data = $urandom;
      sr2_data = $urandom;
      sib_i_data = $urandom;
      seg1_data = 16'($urandom);
      seg2_data = 16'($urandom);
      {nmi_int_en, gen_prot_exc_en, page_fault_exc_en} = '0;
      mem_rd = 1'($urandom);
      mem_wr = 1'($urandom);
      aluk = aluk_w'($urandom);
      {ag2_v, me_v, me2_v, ex_v} = '0;
      ag2_gpr_sb = 24'($urandom);
      me_gpr_sb = 24'($urandom);
      me2_gpr_sb = 24'($urandom);
      ex_gpr_sb = 24'($urandom);
      ag2_seg_sb = 8'($urandom);
      me_seg_sb = 8'($urandom);
      me2_seg_sb = 8'($urandom);
      ex_seg_sb = 8'($urandom);
      ag2_mm_sb = 8'($urandom);
      me_mm_sb = 8'($urandom);
      me2_mm_sb = 8'($urandom);
      ex_mm_sb = 8'($urandom);
   endtask

   // Map the ctl and d columns onto the inputs for this kind
   task automatic apply_stimulus();
      v = 1'b1;
      if (kind == "jmp") begin
         {mux_next_cs, mux_next_eip, jmp_rel} = ctl[2:0];
         eip = d0[31:0];
         offset = d1[47:0];
         cs = d2[15:0];
      end else if (kind == "eff") begin
         {mux_seg, sib_en, disp_en, base_reg_en} = ctl[3:0];
         sib_s = ctl[5:4];
         sr1_data = d0[31:0];
         disp32 = d1[31:0];
         sib_i_data = d2[31:0];
         {cs, seg1_data} = d3[31:0];
      end else if (kind == "stk") begin
         {temp_sp, sp_add_size, sp_push} = ctl[2:0];
         mem_size = ctl[5:4];
         sr2_data = d0[31:0];
      end else if (kind == "dep") begin
         {sib_en, mm2_needed, mm1_needed, seg2_needed} = ctl[6:3];
         {seg1_needed, sr2_needed, sr1_needed} = ctl[2:0];
         sr1_size = ctl[9:8];
         sr2_size = ctl[11:10];
         sr1 = d0[2:0];
         sr2 = d0[6:4];
         sib_i = d0[10:8];
         seg1 = d0[14:12];
         seg2 = d0[18:16];
         {ex_v, me2_v, me_v, ag2_v} = d1[3:0];
         // Stages left invalid keep random scoreboards
         ag2_gpr_sb = ag2_v ? d2[23:0] : ag2_gpr_sb;
         ag2_seg_sb = ag2_v ? d3[15:8] : ag2_seg_sb;
         ag2_mm_sb = ag2_v ? d3[7:0] : ag2_mm_sb;
         me_gpr_sb = me_v ? d2[23:0] : me_gpr_sb;
         me_seg_sb = me_v ? d3[15:8] : me_seg_sb;
         me_mm_sb = me_v ? d3[7:0] : me_mm_sb;
         me2_gpr_sb = me2_v ? d2[23:0] : me2_gpr_sb;
         me2_seg_sb = me2_v ? d3[15:8] : me2_seg_sb;
         me2_mm_sb = me2_v ? d3[7:0] : me2_mm_sb;
         ex_gpr_sb = ex_v ? d2[23:0] : ex_gpr_sb;
         ex_seg_sb = ex_v ? d3[15:8] : ex_seg_sb;
         ex_mm_sb = ex_v ? d3[7:0] : ex_mm_sb;
      end else if (kind == "dst") begin
         {mux_drid1, ld_mm, ld_seg, ld_gpr2, ld_gpr1} = ctl[4:0];
         v = !ctl[5];
         dr1_size = ctl[9:8];
         dr2_size = ctl[11:10];
         sr1 = d0[2:0];
         sr2 = d0[6:4];
      end else if (kind == "irq") begin
         {page_fault_exc_en, gen_prot_exc_en, nmi_int_en} = ctl[2:0];
      end else begin
         $display("Unknown test kind in %0s", name);
         errs++;
      end
   endtask

   task automatic check_value(input string field, input logic [63:0] exp,
                              input logic [63:0] act);
      assert (act === exp)
      else begin
         $display("Mismatch in %0s, %0s: expected %h, actual %h", name, field, exp, act);
         errs++;
      end
   endtask

   task automatic wait_for_valid(output logic ok);
      int cycles;
      cycles = 0;
      while (!ag_v && cycles < 20) begin
         @(negedge clk);
         cycles++;
      end
      ok = ag_v;
      if (!ok) begin
         $display("Timeout in %0s: ag_v never arrived within 20 cycles", name);
         errs++;
      end
   endtask

   task automatic check_results();
      if (kind == "jmp") begin
         check_value("ag_neip", e0, 64'(ag_neip));
         check_value("ag_ncs", e1, 64'(ag_ncs));
      end else if (kind == "eff") begin
         check_value("ag_add_base_disp", e0, 64'(ag_add_base_disp));
         check_value("ag_add_sib_seg1", e1, 64'(ag_add_sib_seg1));
      end else if (kind == "stk") begin
         check_value("ag_sp_addr", e0, 64'(ag_sp_addr));
      end else if (kind == "dst") begin
         check_value("ag_gpr_sb", e0, 64'(ag_gpr_sb));
         check_value("ag_drid1 seg mm", e1, 64'({ag_drid1, ag_seg_sb, ag_mm_sb}));
      end else if (kind == "irq") begin
         check_value("ag_interrupt_addr", e0, 64'(ag_interrupt_addr));
         check_value("ag_exc_en_v", e1, 64'(ag_exc_en_v));
      end
   endtask

   // A picks GPR data, seg1, seg2 or cs, segments zero-extended
   // B picks GPR data or the immediate
   task automatic check_operands();
      logic [addr_w-1:0] exp_a;
      logic [addr_w-1:0] exp_b;
      case (mux_a)
         2'd0:    exp_a = sr1_data;
         2'd1:    exp_a = {16'h0000, seg1_data};
         2'd2:    exp_a = {16'h0000, seg2_data};
         default: exp_a = {16'h0000, cs};
      endcase
      if (mux_b)
         exp_b = imm32;
      else
         exp_b = sr2_data;
      check_value("ag_a", 64'(exp_a), 64'(ag_a));
      check_value("ag_b", 64'(exp_b), 64'(ag_b));
   endtask

   task automatic run_case();
      int   errs_at_start;
      logic expect_valid;
      logic ok;
      errs_at_start = errs;
      drive_idle();
      apply_stimulus();
      expect_valid = v && !(kind == "dep" && e0[0]);
      @(negedge clk);
      // Inputs are still held here, so the stall level and read ids are stable
      if (kind == "dep") begin
         check_value("dep_stall", e0, 64'(dep_stall));
         check_value("read ids",
                     64'({d0[18:16], d0[14:12], d0[10:8], d0[6:4], d0[2:0]}),
                     64'({seg2_out, seg1_out, sib_i_out, sr2_out, sr1_out}));
      end
      if (expect_valid) begin
         wait_for_valid(ok);
         if (ok) begin
            check_results();
            check_operands();
         end
      end else begin
         check_value("ag_v", 64'd0, 64'(ag_v));
         // Bubble must leave the previous payload in place
         if (kind == "dst")
            check_results();
      end
      v = 1'b0;
      n_tests++;
      if (errs == errs_at_start) begin
         $display("ok      %0s", name);
      end else begin
         n_fail++;
         $display("failed  %0s", name);
      end
   endtask

   initial begin
      errs = 0;
      n_tests = 0;
      n_fail = 0;
      void'($urandom(69204));
      drive_idle();
      reset = 1'b1;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      fd = $fopen("dv/agen_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open the cases file dv/agen_cases.txt");
         errs++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            n_fields = $sscanf(line, "%s %s %h %h %h %h %h %h %h",
                               name, kind, ctl, d0, d1, d2, d3, e0, e1);
            // Comment and blank lines never fill all nine columns
            if (n_fields == 9)
               run_case();
         end
         $fclose(fd);
      end
      $display("Tests: %0d run, %0d passed, %0d failed", n_tests, n_tests - n_fail, n_fail);
      if (errs == 0 && n_tests > 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== build.f ====
logic/agen_pkg.sv
logic/pipe_latch.sv
logic/stack_pointer_unit.sv
logic/reg_dependency_check.sv
logic/all_scoreboard_generator.sv
logic/agen_stage1.sv
logic/agen_top.sv
dv/agen_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module agen_tb -o agen_sim -f build.f

output=$(./obj_dir/agen_sim)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -q "RESULT: PASS"

// ==== dv/agen_cases.txt ====
# name kind ctl d0 d1 d2 d3 e0 e1, one test per line, all numbers in hex
# meaning of ctl and the d and e columns depends on the kind, see the testbench
jmp_rel        jmp 1   00401000 000000000010 0008     0        00401010 0008
jmp_rel_back   jmp 1   00401000 0000fffffff0 0008     0        00400ff0 0008
jmp_none       jmp 0   00401000 000000000123 0008     0        00401000 0008
jmp_abs        jmp 2   00401000 000000402000 0008     0        00402000 0008
jmp_far        jmp 6   00401000 001b00500000 0008     0        00500000 001b
ea_base        eff 01  00001000 00000044     00000010 f0000020 00001000 00200000
ea_disp        eff 02  00001000 00000044     00000010 f0000020 00000044 00200000
ea_sib_s1      eff 17  00001000 00000044     00000010 f0000020 00001044 00200020
ea_sib_s2      eff 27  00001000 00000044     00000010 f0000020 00001044 00200040
ea_sib_s3      eff 37  00001000 00000044     00000010 f0000020 00001044 00200080
ea_cs_override eff 0f  00001000 00000044     00000010 f0000020 00001044 f0000010
sp_push16      stk 11  00001000 0            0        0        00000ffe 0
sp_push32      stk 21  00002000 0            0        0        00001ffc 0
sp_push64      stk 31  00003000 0            0        0        00002ff8 0
sp_pop_first   stk 20  00004000 0            0        0        00004000 0
sp_pop32_next  stk 27  00000000 0            0        0        00004004 0
sp_pop16_next  stk 17  00000000 0            0        0        00004008 0
sp_pop16_last  stk 17  00000000 0            0        0        0000400a 0
sp_push_temp   stk 35  00000000 0            0        0        00004002 0
dep_ag2_lane   dep 101 00000002 1            00000080 0000     1        0
dep_ag2_free   dep 101 00000002 1            00000100 0000     0        0
dep_me_sib     dep 040 00000500 2            00020000 0000     1        0
dep_me_free    dep 040 00000500 2            00007000 0000     0        0
dep_me2_seg    dep 004 00003000 4            00000000 0800     1        0
dep_me2_free   dep 008 00010000 4            00000000 0800     0        0
dep_ex_mm      dep 020 00000060 8            00000000 0040     1        0
dep_ex_free    dep 002 00000060 8            00180000 0000     0        0
sb_two_gpr     dst 203 00000071 0            0        0        00200038 00010000
sb_swap_seg    dst 115 00000030 0            0        0        00000600 00030800
sb_mm_gpr2     dst 40a 00000004 0            0        0        00000003 00040010
sb_no_valid    dst 22f 00000055 0            0        0        00000003 00040010
irq_none       irq 0   0        0            0        0        00000010 0
irq_nmi        irq 1   0        0            0        0        00000010 1
irq_gp         irq 2   0        0            0        0        00000068 1
irq_gp_nmi     irq 3   0        0            0        0        00000068 1
irq_pf         irq 4   0        0            0        0        00000070 1
irq_pf_nmi     irq 5   0        0            0        0        00000070 1
irq_pf_gp      irq 6   0        0            0        0        00000068 1
irq_all        irq 7   0        0            0        0        00000068 1
